// File: rv_pkg.sv
// shared constants, opcode and control enums, decoder control and commit trace structs
package rv_pkg;

  localparam int XLEN = 64;
  localparam logic [XLEN-1:0] RESET_PC = 64'h0;

  typedef enum logic [6:0] {
    OPC_LUI       = 7'b0110111,
    OPC_AUIPC     = 7'b0010111,
    OPC_JAL       = 7'b1101111,
    OPC_JALR      = 7'b1100111,
    OPC_BRANCH    = 7'b1100011,
    OPC_LOAD      = 7'b0000011,
    OPC_STORE     = 7'b0100011,
    OPC_OP_IMM    = 7'b0010011,
    OPC_OP_IMM_32 = 7'b0011011,
    OPC_OP        = 7'b0110011,
    OPC_OP_32     = 7'b0111011,
    OPC_SYSTEM    = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_COPY_B
  } alu_op_e;

  // nine kinds, so four bits
  typedef enum logic [3:0] {
    BR_NONE, BR_JAL, BR_JALR, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
  } br_op_e;

  typedef enum logic [2:0] {
    MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW, MEM_LWU, MEM_LD, MEM_NONE
  } mem_op_e;

  typedef enum logic {A_RS1, A_PC} a_src_e;

  typedef enum logic [1:0] {B_RS2, B_IMM, B_FOUR} b_src_e;

  typedef enum logic [2:0] {S_FETCH, S_EXEC, S_MEM, S_WB, S_STOP} state_e;

  typedef struct packed {
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic [XLEN-1:0] imm;
    alu_op_e         alu_op;
    a_src_e          a_src;
    b_src_e          b_src;
    br_op_e          br_op;
    mem_op_e         mem_op;
    logic            reg_wr;
    logic            mem_wr;
    logic            mem_rd;
    logic            word_cut; // 32-bit op, result sign-extended
    logic            illegal;
    logic            ebreak;
  } ctrl_t;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [31:0]     inst;
    logic [4:0]      rd;
    logic            wr_en;
    logic [XLEN-1:0] wdata;
    logic [XLEN-1:0] next_pc;
  } commit_t;

endpackage

// File: rv_decode.sv
// rv64i instruction decoder producing the control struct and sign-extended immediate
`timescale 1ns/1ns

module rv_decode (
  input  logic [31:0]   i_inst,
  output rv_pkg::ctrl_t o_ctrl
);

  rv_pkg::opcode_e opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic        f7_zero;
  logic        f7_alt;
  logic [63:0] imm_i;
  logic [63:0] imm_u;
  logic [63:0] imm_s;
  logic [63:0] imm_b;
  logic [63:0] imm_j;
  rv_pkg::ctrl_t c;

  assign opcode  = rv_pkg::opcode_e'(i_inst[6:0]);
  assign funct3  = i_inst[14:12];
  assign funct7  = i_inst[31:25];
  assign f7_zero = (funct7 == 7'b0000000);
  assign f7_alt  = (funct7 == 7'b0100000);

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{52{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_j = {{44{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  // shared funct3 map of OP and OP_IMM groups, alt picks sub/sra
  function automatic rv_pkg::alu_op_e f3_alu(input logic [2:0] f3, input logic alt);
    rv_pkg::alu_op_e op;
    case (f3)
      3'b000:  op = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
      3'b001:  op = rv_pkg::ALU_SLL;
      3'b010:  op = rv_pkg::ALU_SLT;
      3'b011:  op = rv_pkg::ALU_SLTU;
      3'b100:  op = rv_pkg::ALU_XOR;
      3'b101:  op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      3'b110:  op = rv_pkg::ALU_OR;
      default: op = rv_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    c          = '0;
    c.rs1      = i_inst[19:15];
    c.rs2      = i_inst[24:20];
    c.rd       = i_inst[11:7];
    c.imm      = imm_i;
    c.alu_op   = rv_pkg::ALU_ADD;
    c.a_src    = rv_pkg::A_RS1;
    c.b_src    = rv_pkg::B_IMM;
    c.br_op    = rv_pkg::BR_NONE;
    c.mem_op   = rv_pkg::MEM_NONE;
    c.illegal  = 1'b1; // cleared by a match
    case (opcode)
      rv_pkg::OPC_LUI: begin
        c.imm     = imm_u;
        c.alu_op  = rv_pkg::ALU_COPY_B;
        c.reg_wr  = 1'b1;
        c.illegal = 1'b0;
      end
      rv_pkg::OPC_AUIPC: begin
        c.imm     = imm_u;
        c.a_src   = rv_pkg::A_PC;
        c.reg_wr  = 1'b1;
        c.illegal = 1'b0;
      end
      rv_pkg::OPC_JAL: begin
        c.imm     = imm_j;
        c.a_src   = rv_pkg::A_PC;
        c.b_src   = rv_pkg::B_FOUR; // link value pc + 4
        c.br_op   = rv_pkg::BR_JAL;
        c.reg_wr  = 1'b1;
        c.illegal = 1'b0;
      end
      rv_pkg::OPC_JALR: begin
        c.a_src   = rv_pkg::A_PC;
        c.b_src   = rv_pkg::B_FOUR;
        c.br_op   = rv_pkg::BR_JALR;
        c.reg_wr  = 1'b1;
        c.illegal = (funct3 != 3'b000);
      end
      rv_pkg::OPC_BRANCH: begin
        c.imm     = imm_b;
        c.illegal = 1'b0;
        case (funct3)
          3'b000:  c.br_op = rv_pkg::BR_BEQ;
          3'b001:  c.br_op = rv_pkg::BR_BNE;
          3'b100:  c.br_op = rv_pkg::BR_BLT;
          3'b101:  c.br_op = rv_pkg::BR_BGE;
          3'b110:  c.br_op = rv_pkg::BR_BLTU;
          3'b111:  c.br_op = rv_pkg::BR_BGEU;
          default: c.illegal = 1'b1;
        endcase
      end
      rv_pkg::OPC_LOAD: begin
        c.mem_rd  = 1'b1;
        c.reg_wr  = 1'b1;
        c.mem_op  = rv_pkg::mem_op_e'({funct3[1:0], funct3[2]}); // enum order matches
        c.illegal = (funct3 == 3'b111);
      end
      rv_pkg::OPC_STORE: begin
        c.imm     = imm_s;
        c.mem_wr  = 1'b1;
        c.mem_op  = rv_pkg::mem_op_e'({funct3[1:0], 1'b0});
        c.illegal = funct3[2];
      end
      rv_pkg::OPC_OP_IMM: begin
        c.alu_op  = f3_alu(funct3, (funct3 == 3'b101) && funct7[5]);
        c.reg_wr  = 1'b1;
        c.illegal = ((funct3 == 3'b001) && (funct7[6:1] != 6'b000000)) ||
                    ((funct3 == 3'b101) && (funct7[6:1] != 6'b000000) &&
                     (funct7[6:1] != 6'b010000));
      end
      rv_pkg::OPC_OP_IMM_32: begin
        c.alu_op   = f3_alu(funct3, (funct3 == 3'b101) && funct7[5]);
        c.reg_wr   = 1'b1;
        c.word_cut = 1'b1;
        c.illegal  = !((funct3 == 3'b000) || ((funct3 == 3'b001) && f7_zero) ||
                       ((funct3 == 3'b101) && (f7_zero || f7_alt)));
      end
      rv_pkg::OPC_OP: begin
        c.b_src   = rv_pkg::B_RS2;
        c.alu_op  = f3_alu(funct3, funct7[5]);
        c.reg_wr  = 1'b1;
        c.illegal = !(f7_zero || (f7_alt && (funct3 inside {3'b000, 3'b101})));
      end
      rv_pkg::OPC_OP_32: begin
        c.b_src    = rv_pkg::B_RS2;
        c.alu_op   = f3_alu(funct3, funct7[5]);
        c.reg_wr   = 1'b1;
        c.word_cut = 1'b1;
        c.illegal  = !((f7_zero && (funct3 inside {3'b000, 3'b001, 3'b101})) ||
                       (f7_alt && (funct3 inside {3'b000, 3'b101})));
      end
      rv_pkg::OPC_SYSTEM: begin
        c.ebreak  = (i_inst == 32'h0010_0073);
        c.illegal = !c.ebreak; // only ebreak supported
      end
      default: ;
    endcase
    if (c.illegal) begin
      c.reg_wr = 1'b0;
      c.mem_rd = 1'b0;
      c.mem_wr = 1'b0;
      c.mem_op = rv_pkg::MEM_NONE;
      c.br_op  = rv_pkg::BR_NONE;
    end
  end

  assign o_ctrl = c;

endmodule

// File: rv_execute.sv
// 64-bit alu with word truncation, branch comparator and jump target adder
`timescale 1ns/1ns

module rv_execute (
  input  rv_pkg::ctrl_t               i_ctrl,
  input  logic [rv_pkg::XLEN-1:0]     i_pc,
  input  logic [rv_pkg::XLEN-1:0]     i_rs1,
  input  logic [rv_pkg::XLEN-1:0]     i_rs2,
  output logic [rv_pkg::XLEN-1:0]     o_alu,
  output logic                        o_taken,
  output logic [rv_pkg::XLEN-1:0]     o_target
);

  logic [63:0] op_a;
  logic [63:0] op_b;
  logic [63:0] shift_src;
  logic [5:0]  shamt;
  logic [63:0] res;
  logic [63:0] base;
  logic [63:0] sum;

  assign op_a = (i_ctrl.a_src == rv_pkg::A_PC) ? i_pc : i_rs1;

  always_comb begin
    case (i_ctrl.b_src)
      rv_pkg::B_RS2: op_b = i_rs2;
      rv_pkg::B_IMM: op_b = i_ctrl.imm;
      default:       op_b = 64'd4;
    endcase
  end

  // word shifts see only the low 32 bits, extended as the shift needs
  always_comb begin
    shift_src = op_a;
    shamt     = op_b[5:0];
    if (i_ctrl.word_cut) begin
      shamt = {1'b0, op_b[4:0]};
      if (i_ctrl.alu_op == rv_pkg::ALU_SRA) begin
        shift_src = {{32{op_a[31]}}, op_a[31:0]};
      end else begin
        shift_src = {32'b0, op_a[31:0]};
      end
    end
  end

  always_comb begin
    case (i_ctrl.alu_op)
      rv_pkg::ALU_SUB:    res = op_a - op_b;
      rv_pkg::ALU_SLL:    res = shift_src << shamt;
      rv_pkg::ALU_SLT:    res = {63'b0, $signed(op_a) < $signed(op_b)};
      rv_pkg::ALU_SLTU:   res = {63'b0, op_a < op_b};
      rv_pkg::ALU_XOR:    res = op_a ^ op_b;
      rv_pkg::ALU_SRL:    res = shift_src >> shamt;
      rv_pkg::ALU_SRA:    res = $unsigned($signed(shift_src) >>> shamt);
      rv_pkg::ALU_OR:     res = op_a | op_b;
      rv_pkg::ALU_AND:    res = op_a & op_b;
      rv_pkg::ALU_COPY_B: res = op_b;
      default:            res = op_a + op_b;
    endcase
  end

  assign o_alu = i_ctrl.word_cut ? {{32{res[31]}}, res[31:0]} : res;

  always_comb begin
    case (i_ctrl.br_op)
      rv_pkg::BR_JAL,
      rv_pkg::BR_JALR: o_taken = 1'b1;
      rv_pkg::BR_BEQ:  o_taken = (i_rs1 == i_rs2);
      rv_pkg::BR_BNE:  o_taken = (i_rs1 != i_rs2);
      rv_pkg::BR_BLT:  o_taken = ($signed(i_rs1) < $signed(i_rs2));
      rv_pkg::BR_BGE:  o_taken = ($signed(i_rs1) >= $signed(i_rs2));
      rv_pkg::BR_BLTU: o_taken = (i_rs1 < i_rs2);
      rv_pkg::BR_BGEU: o_taken = (i_rs1 >= i_rs2);
      default:         o_taken = 1'b0;
    endcase
  end

  assign base     = (i_ctrl.br_op == rv_pkg::BR_JALR) ? i_rs1 : i_pc;
  assign sum      = base + i_ctrl.imm;
  assign o_target = {sum[63:1], sum[0] & (i_ctrl.br_op != rv_pkg::BR_JALR)}; // jalr clears bit 0

endmodule

// File: rv_regfile.sv
// 31 x 64-bit register file, two combinational read ports, one write port, x0 reads zero
`timescale 1ns/1ns

module rv_regfile (
  input  logic                    i_clk,
  input  logic                    i_rst,
  input  logic [4:0]              i_ra,
  input  logic [4:0]              i_rb,
  input  logic                    i_we,
  input  logic [4:0]              i_rd,
  input  logic [rv_pkg::XLEN-1:0] i_wdata,
  output logic [rv_pkg::XLEN-1:0] o_a,
  output logic [rv_pkg::XLEN-1:0] o_b
);

  logic [rv_pkg::XLEN-1:0] regs [1:31];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && (i_rd != 5'd0)) begin
      regs[i_rd] <= i_wdata;
    end
  end

  assign o_a = (i_ra == 5'd0) ? '0 : regs[i_ra];
  assign o_b = (i_rb == 5'd0) ? '0 : regs[i_rb];

endmodule

// File: rv_result.sv
// store lane placement and byte select, load extraction and extension, writeback select
`timescale 1ns/1ns

module rv_result (
  input  rv_pkg::ctrl_t           i_ctrl,
  input  logic [rv_pkg::XLEN-1:0] i_addr,
  input  logic [rv_pkg::XLEN-1:0] i_alu,
  input  logic [rv_pkg::XLEN-1:0] i_rs2,
  input  logic [rv_pkg::XLEN-1:0] i_rdata,
  output logic [rv_pkg::XLEN-1:0] o_wdata_bus,
  output logic [7:0]              o_sel,
  output logic [rv_pkg::XLEN-1:0] o_wb_value
);

  logic [5:0]  lane_shift;
  logic [7:0]  size_mask;
  logic [63:0] lane;
  logic [63:0] load_val;

  assign lane_shift  = {i_addr[2:0], 3'b000}; // byte offset in bits
  assign o_wdata_bus = i_rs2 << lane_shift;
  assign lane        = i_rdata >> lane_shift;

  always_comb begin
    case (i_ctrl.mem_op)
      rv_pkg::MEM_LB,
      rv_pkg::MEM_LBU:  size_mask = 8'h01;
      rv_pkg::MEM_LH,
      rv_pkg::MEM_LHU:  size_mask = 8'h03;
      rv_pkg::MEM_LW,
      rv_pkg::MEM_LWU:  size_mask = 8'h0f;
      rv_pkg::MEM_LD:   size_mask = 8'hff;
      default:          size_mask = 8'h00;
    endcase
  end

  assign o_sel = size_mask << i_addr[2:0];

  always_comb begin
    case (i_ctrl.mem_op)
      rv_pkg::MEM_LB:  load_val = {{56{lane[7]}}, lane[7:0]};
      rv_pkg::MEM_LBU: load_val = {56'b0, lane[7:0]};
      rv_pkg::MEM_LH:  load_val = {{48{lane[15]}}, lane[15:0]};
      rv_pkg::MEM_LHU: load_val = {48'b0, lane[15:0]};
      rv_pkg::MEM_LW:  load_val = {{32{lane[31]}}, lane[31:0]};
      rv_pkg::MEM_LWU: load_val = {32'b0, lane[31:0]};
      default:         load_val = lane;
    endcase
  end

  // jumps land here via alu, operand b is four
  assign o_wb_value = i_ctrl.mem_rd ? load_val : i_alu;

endmodule

// File: rv_core.sv
// multicycle rv64i core top, state sequence, pc, wishbone classic master and commit trace
`timescale 1ns/1ns

module rv_core (
  input  logic                    i_clk,
  input  logic                    i_rst,
  input  logic [rv_pkg::XLEN-1:0] i_wb_dat,
  input  logic                    i_wb_ack,
  output logic                    o_wb_cyc,
  output logic                    o_wb_stb,
  output logic                    o_wb_we,
  output logic [rv_pkg::XLEN-1:0] o_wb_adr,
  output logic [rv_pkg::XLEN-1:0] o_wb_dat,
  output logic [7:0]              o_wb_sel,
  output logic                    o_commit_valid,
  output rv_pkg::commit_t         o_commit,
  output logic                    o_halt,
  output logic                    o_illegal
);

  rv_pkg::state_e          state;
  rv_pkg::ctrl_t           ctrl;
  logic [rv_pkg::XLEN-1:0] pc;
  logic [31:0]             ir;
  logic [rv_pkg::XLEN-1:0] rdata;
  logic [rv_pkg::XLEN-1:0] rs1_val;
  logic [rv_pkg::XLEN-1:0] rs2_val;
  logic [rv_pkg::XLEN-1:0] alu;
  logic                    taken;
  logic [rv_pkg::XLEN-1:0] target;
  logic [rv_pkg::XLEN-1:0] wb_value;
  logic [7:0]              mem_sel;
  logic [rv_pkg::XLEN-1:0] next_pc;
  logic                    in_mem;
  logic                    in_wb;

  assign in_mem  = (state == rv_pkg::S_MEM);
  assign in_wb   = (state == rv_pkg::S_WB);
  assign next_pc = taken ? target : pc + 64'd4;

  rv_decode u_decode (.i_inst(ir), .o_ctrl(ctrl));

  rv_regfile u_regfile (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_ra    (ctrl.rs1),
    .i_rb    (ctrl.rs2),
    .i_we    (in_wb && ctrl.reg_wr),
    .i_rd    (ctrl.rd),
    .i_wdata (wb_value),
    .o_a     (rs1_val),
    .o_b     (rs2_val)
  );

  rv_execute u_execute (
    .i_ctrl   (ctrl),
    .i_pc     (pc),
    .i_rs1    (rs1_val),
    .i_rs2    (rs2_val),
    .o_alu    (alu),
    .o_taken  (taken),
    .o_target (target)
  );

  rv_result u_result (
    .i_ctrl      (ctrl),
    .i_addr      (alu),
    .i_alu       (alu),
    .i_rs2       (rs2_val),
    .i_rdata     (rdata),
    .o_wdata_bus (o_wb_dat),
    .o_sel       (mem_sel),
    .o_wb_value  (wb_value)
  );

  // bus request follows the state, held steady until ack
  assign o_wb_cyc = !i_rst && ((state == rv_pkg::S_FETCH) || in_mem);
  assign o_wb_stb = o_wb_cyc;
  assign o_wb_we  = in_mem && ctrl.mem_wr;
  assign o_wb_adr = in_mem ? alu : {pc[63:3], 3'b000};
  assign o_wb_sel = in_mem ? mem_sel : 8'hff;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state     <= rv_pkg::S_FETCH;
      pc        <= rv_pkg::RESET_PC;
      o_halt    <= 1'b0;
      o_illegal <= 1'b0;
    end else begin
      case (state)
        rv_pkg::S_FETCH: if (i_wb_ack) state <= rv_pkg::S_EXEC;
        rv_pkg::S_EXEC: begin
          state <= (ctrl.mem_rd || ctrl.mem_wr) ? rv_pkg::S_MEM : rv_pkg::S_WB;
        end
        rv_pkg::S_MEM: if (i_wb_ack) state <= rv_pkg::S_WB;
        rv_pkg::S_WB: begin
          pc <= next_pc;
          if (ctrl.ebreak || ctrl.illegal) begin
            state <= rv_pkg::S_STOP; // held until reset
          end else begin
            state <= rv_pkg::S_FETCH;
          end
          o_halt    <= ctrl.ebreak;
          o_illegal <= ctrl.illegal;
        end
        default: state <= rv_pkg::S_STOP;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if ((state == rv_pkg::S_FETCH) && i_wb_ack) begin
      ir <= pc[2] ? i_wb_dat[63:32] : i_wb_dat[31:0]; // upper half for pc bit 2
    end
    if (in_mem && i_wb_ack) begin
      rdata <= i_wb_dat;
    end
  end

  assign o_commit_valid = in_wb;

  always_comb begin
    o_commit.pc      = pc;
    o_commit.inst    = ir;
    o_commit.rd      = ctrl.rd;
    o_commit.wr_en   = ctrl.reg_wr;
    o_commit.wdata   = wb_value;
    o_commit.next_pc = next_pc;
  end

endmodule

// File: tb_wb_mem.sv
// wishbone classic slave memory model with random wait states and a preload port
`timescale 1ns/1ns

module tb_wb_mem (
  input  logic        i_clk,
  input  logic        i_rst,
  input  logic        i_cyc,
  input  logic        i_stb,
  input  logic        i_we,
  input  logic [63:0] i_adr,
  input  logic [63:0] i_dat,
  input  logic [7:0]  i_sel,
  input  logic        i_clear,
  input  logic        i_load_we,
  input  logic [63:0] i_load_adr,
  input  logic [31:0] i_load_dat,
  output logic [63:0] o_dat,
  output logic        o_ack
);

  logic [63:0] mem [0:255];
  logic [1:0]  wait_left;
  logic        armed;
  logic [7:0]  idx;

  assign idx = i_adr[10:3]; // doubleword index, low bits ignored

  always_ff @(posedge i_clk) begin
    if (i_clear) begin
      for (int k = 0; k < 256; k++) begin
        mem[k] <= '0;
      end
    end else if (i_load_we) begin
      if (i_load_adr[2]) begin
        mem[i_load_adr[10:3]][63:32] <= i_load_dat;
      end else begin
        mem[i_load_adr[10:3]][31:0] <= i_load_dat;
      end
    end
    if (i_rst) begin
      o_ack     <= 1'b0;
      o_dat     <= '0;
      armed     <= 1'b0;
      wait_left <= 2'd0;
    end else if (o_ack) begin
      o_ack <= 1'b0; // single cycle ack
    end else if (i_cyc && i_stb) begin
      if (!armed) begin
        wait_left <= 2'($urandom % 4);
        armed     <= 1'b1;
      end else if (wait_left != 2'd0) begin
        wait_left <= wait_left - 2'd1;
      end else begin
        o_ack <= 1'b1;
        armed <= 1'b0;
        o_dat <= mem[idx];
        if (i_we) begin
          for (int b = 0; b < 8; b++) begin
            if (i_sel[b]) begin
              mem[idx][b*8 +: 8] <= i_dat[b*8 +: 8];
            end
          end
        end
      end
    end
  end

endmodule

// File: tb_rv_core.sv
// testbench top: clock, reset, program and commit expectation table, checks, timeout
`timescale 1ns/1ns

module tb_rv_core;

  localparam int MAX_N = 64;

  logic            clk;
  logic            rst;
  logic            wb_cyc;
  logic            wb_stb;
  logic            wb_we;
  logic [63:0]     wb_adr;
  logic [63:0]     wb_dat_w;
  logic [63:0]     wb_dat_r;
  logic [7:0]      wb_sel;
  logic            wb_ack;
  logic            commit_valid;
  rv_pkg::commit_t commit;
  logic            halt;
  logic            illegal;
  logic            mem_clear;
  logic            load_we;
  logic [63:0]     load_adr;
  logic [31:0]     load_dat;

  logic [63:0] t_pc    [MAX_N];
  logic [31:0] t_inst  [MAX_N];
  logic [4:0]  t_rd    [MAX_N];
  logic        t_we    [MAX_N];
  logic [63:0] t_wdata [MAX_N];
  logic [63:0] t_next  [MAX_N];
  int          n_entries;
  int          n_main;
  int          errors;
  int          checks;
  bit          timed_out;

  rv_core UUT (
    .i_clk          (clk),
    .i_rst          (rst),
    .i_wb_dat       (wb_dat_r),
    .i_wb_ack       (wb_ack),
    .o_wb_cyc       (wb_cyc),
    .o_wb_stb       (wb_stb),
    .o_wb_we        (wb_we),
    .o_wb_adr       (wb_adr),
    .o_wb_dat       (wb_dat_w),
    .o_wb_sel       (wb_sel),
    .o_commit_valid (commit_valid),
    .o_commit       (commit),
    .o_halt         (halt),
    .o_illegal      (illegal)
  );

  tb_wb_mem u_mem (
    .i_clk      (clk),
    .i_rst      (rst),
    .i_cyc      (wb_cyc),
    .i_stb      (wb_stb),
    .i_we       (wb_we),
    .i_adr      (wb_adr),
    .i_dat      (wb_dat_w),
    .i_sel      (wb_sel),
    .i_clear    (mem_clear),
    .i_load_we  (load_we),
    .i_load_adr (load_adr),
    .i_load_dat (load_dat),
    .o_dat      (wb_dat_r),
    .o_ack      (wb_ack)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // instruction encoders by format
  function automatic logic [31:0] r_type(int f7, int rs2, int rs1, int f3, int rd, int op);
    logic [31:0] w;
    w = {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    return w;
  endfunction

  function automatic logic [31:0] i_type(int imm, int rs1, int f3, int rd, int op);
    logic [31:0] w;
    w = {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    return w;
  endfunction

  function automatic logic [31:0] s_type(int imm, int rs2, int rs1, int f3);
    logic [31:0] w;
    w = {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
    return w;
  endfunction

  function automatic logic [31:0] b_type(int imm, int rs2, int rs1, int f3);
    logic [31:0] w;
    w = {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
    return w;
  endfunction

  function automatic logic [31:0] u_type(int imm20, int rd, int op);
    logic [31:0] w;
    w = {imm20[19:0], rd[4:0], op[6:0]};
    return w;
  endfunction

  function automatic logic [31:0] j_type(int imm, int rd);
    logic [31:0] w;
    w = {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
    return w;
  endfunction

  task automatic add_entry(int pc, logic [31:0] inst, int rd, logic we, logic [63:0] wdata,
                           int next_pc);
    t_pc[n_entries]    = 64'(pc);
    t_inst[n_entries]  = inst;
    t_rd[n_entries]    = rd[4:0];
    t_we[n_entries]    = we;
    t_wdata[n_entries] = wdata;
    t_next[n_entries]  = 64'(next_pc);
    n_entries++;
  endtask

  task automatic build_table();
    n_entries = 0;
    add_entry(0,   i_type(5, 0, 0, 1, 'h13),        1, 1'b1, 64'h5, 4);
    add_entry(4,   i_type(-3, 0, 0, 2, 'h13),       2, 1'b1, 64'hffff_ffff_ffff_fffd, 8);
    add_entry(8,   r_type(0, 2, 1, 0, 3, 'h33),     3, 1'b1, 64'h2, 12);
    add_entry(12,  r_type(32, 2, 1, 0, 4, 'h33),    4, 1'b1, 64'h8, 16);
    add_entry(16,  r_type(0, 1, 2, 2, 5, 'h33),     5, 1'b1, 64'h1, 20);
    add_entry(20,  r_type(0, 1, 2, 3, 6, 'h33),     6, 1'b1, 64'h0, 24);
    add_entry(24,  r_type(0, 2, 1, 4, 7, 'h33),     7, 1'b1, 64'hffff_ffff_ffff_fff8, 28);
    add_entry(28,  r_type(0, 2, 1, 6, 8, 'h33),     8, 1'b1, 64'hffff_ffff_ffff_fffd, 32);
    add_entry(32,  r_type(0, 2, 1, 7, 9, 'h33),     9, 1'b1, 64'h5, 36);
    add_entry(36,  i_type(60, 1, 1, 10, 'h13),      10, 1'b1, 64'h5000_0000_0000_0000, 40);
    add_entry(40,  i_type(60, 2, 5, 11, 'h13),      11, 1'b1, 64'hf, 44);
    add_entry(44,  i_type('h401, 2, 5, 12, 'h13),   12, 1'b1, 64'hffff_ffff_ffff_fffe, 48);
    add_entry(48,  u_type('h12345, 13, 'h37),       13, 1'b1, 64'h1234_5000, 52);
    add_entry(52,  u_type(1, 14, 'h17),             14, 1'b1, 64'h1034, 56);
    add_entry(56,  i_type(7, 1, 0, 0, 'h13),        0, 1'b1, 64'hc, 60); // x0 target
    add_entry(60,  r_type(0, 1, 0, 0, 15, 'h33),    15, 1'b1, 64'h5, 64);
    // word ops
    add_entry(64,  u_type('h80000, 16, 'h37),       16, 1'b1, 64'hffff_ffff_8000_0000, 68);
    add_entry(68,  i_type(-1, 16, 0, 16, 'h1b),     16, 1'b1, 64'h7fff_ffff, 72);
    add_entry(72,  i_type(1, 16, 0, 17, 'h1b),      17, 1'b1, 64'hffff_ffff_8000_0000, 76);
    add_entry(76,  r_type(0, 1, 16, 0, 18, 'h3b),   18, 1'b1, 64'hffff_ffff_8000_0004, 80);
    add_entry(80,  r_type(32, 16, 1, 0, 19, 'h3b),  19, 1'b1, 64'hffff_ffff_8000_0006, 84);
    add_entry(84,  i_type(31, 1, 1, 20, 'h1b),      20, 1'b1, 64'hffff_ffff_8000_0000, 88);
    add_entry(88,  r_type(0, 1, 17, 5, 21, 'h3b),   21, 1'b1, 64'h0400_0000, 92);
    add_entry(92,  r_type(32, 1, 17, 5, 22, 'h3b),  22, 1'b1, 64'hffff_ffff_fc00_0000, 96);
    // memory at 0x400
    add_entry(96,  i_type(1024, 0, 0, 23, 'h13),    23, 1'b1, 64'h400, 100);
    add_entry(100, s_type(0, 2, 23, 0),             0, 1'b0, 64'h0, 104);
    add_entry(104, s_type(2, 13, 23, 1),            0, 1'b0, 64'h0, 108);
    add_entry(108, s_type(4, 16, 23, 2),            0, 1'b0, 64'h0, 112);
    add_entry(112, s_type(8, 2, 23, 3),             0, 1'b0, 64'h0, 116);
    add_entry(116, i_type(0, 23, 0, 24, 'h03),      24, 1'b1, 64'hffff_ffff_ffff_fffd, 120);
    add_entry(120, i_type(0, 23, 4, 25, 'h03),      25, 1'b1, 64'hfd, 124);
    add_entry(124, i_type(2, 23, 1, 26, 'h03),      26, 1'b1, 64'h5000, 128);
    add_entry(128, i_type(8, 23, 5, 27, 'h03),      27, 1'b1, 64'hfffd, 132);
    add_entry(132, i_type(4, 23, 2, 28, 'h03),      28, 1'b1, 64'h7fff_ffff, 136);
    add_entry(136, i_type(8, 23, 3, 29, 'h03),      29, 1'b1, 64'hffff_ffff_ffff_fffd, 140);
    // branches and jumps
    add_entry(140, b_type(8, 15, 1, 0),             0, 1'b0, 64'h0, 148);
    add_entry(148, b_type(8, 15, 1, 1),             0, 1'b0, 64'h0, 152);
    add_entry(152, b_type(8, 1, 2, 4),              0, 1'b0, 64'h0, 160);
    add_entry(160, b_type(8, 1, 2, 5),              0, 1'b0, 64'h0, 164);
    add_entry(164, b_type(8, 1, 2, 6),              0, 1'b0, 64'h0, 168);
    add_entry(168, b_type(8, 1, 2, 7),              0, 1'b0, 64'h0, 176);
    // same kinds the other way
    add_entry(176, b_type(8, 2, 1, 0),              0, 1'b0, 64'h0, 180);
    add_entry(180, b_type(8, 2, 1, 1),              0, 1'b0, 64'h0, 188);
    add_entry(188, b_type(8, 2, 1, 4),              0, 1'b0, 64'h0, 192);
    add_entry(192, b_type(8, 2, 1, 5),              0, 1'b0, 64'h0, 200);
    add_entry(200, b_type(8, 2, 1, 6),              0, 1'b0, 64'h0, 208);
    add_entry(208, b_type(8, 2, 1, 7),              0, 1'b0, 64'h0, 212);
    add_entry(212, j_type(8, 30),                   30, 1'b1, 64'hd8, 220);
    add_entry(220, i_type(233, 0, 0, 31, 'h13),     31, 1'b1, 64'he9, 224);
    add_entry(224, i_type(0, 31, 0, 5, 'h67),       5, 1'b1, 64'he4, 232); // odd target
    add_entry(232, 32'h0010_0073,                   0, 1'b0, 64'h0, 236);
    n_main = n_entries;
    // second run, all-zero word at the reset pc
    add_entry(0,   32'h0,                           0, 1'b0, 64'h0, 4);
  endtask

  task automatic check_field(string name, logic [63:0] exp, logic [63:0] act);
    checks++;
    if (exp !== act) begin
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic load_program(int first, int count);
    @(posedge clk);
    mem_clear <= 1'b1;
    @(posedge clk);
    mem_clear <= 1'b0;
    for (int i = first; i < first + count; i++) begin
      load_we  <= 1'b1;
      load_adr <= t_pc[i];
      load_dat <= t_inst[i];
      @(posedge clk);
    end
    load_we <= 1'b0;
  endtask

  task automatic reset_core();
    rst <= 1'b1;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
  endtask

  // compares commits against the expected records in order
  task automatic run_commits(int first, int count);
    int idx;
    int cycles;
    int limit;
    idx    = first;
    cycles = 0;
    limit  = count * 20;
    while (idx < first + count && !timed_out) begin
      @(negedge clk);
      cycles++;
      if (commit_valid) begin
        check_field("pc", t_pc[idx], commit.pc);
        check_field("inst", 64'(t_inst[idx]), 64'(commit.inst));
        check_field("wr_en", 64'(t_we[idx]), 64'(commit.wr_en));
        check_field("next_pc", t_next[idx], commit.next_pc);
        if (t_we[idx]) begin
          check_field("rd", 64'(t_rd[idx]), 64'(commit.rd));
          check_field("wdata", t_wdata[idx], commit.wdata);
        end
        idx++;
      end
      if (cycles >= limit && idx < first + count) begin
        $display("timeout after %0d cycles, %0d of %0d commits seen",
                 cycles, idx - first, count);
        timed_out = 1'b1;
      end
    end
  endtask

  // stop flags hold and no commit follows
  task automatic watch_stop(logic want_halt);
    repeat (20) begin
      @(negedge clk);
      check_field("o_halt", 64'(want_halt), 64'(halt));
      check_field("o_illegal", 64'(!want_halt), 64'(illegal));
      checks++;
      if (commit_valid) begin
        $display("commit seen after the core stopped");
        errors++;
      end
    end
  endtask

  initial begin
    void'($urandom(32'h3dc5));
    rst       = 1'b1;
    mem_clear = 1'b0;
    load_we   = 1'b0;
    load_adr  = '0;
    load_dat  = '0;
    errors    = 0;
    checks    = 0;
    timed_out = 1'b0;
    build_table();
    load_program(0, n_main);
    reset_core();
    run_commits(0, n_main);
    if (!timed_out) begin
      watch_stop(1'b1);
    end
    if (!timed_out) begin
      load_program(n_main, 1);
      reset_core();
      run_commits(n_main, 1);
    end
    if (!timed_out) begin
      watch_stop(1'b0);
    end
    $display("checks: %0d, errors: %0d, timeout: %0d", checks, errors, timed_out);
    if (errors == 0 && !timed_out) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: list.f
rv_pkg.sv
rv_decode.sv
rv_execute.sv
rv_regfile.sv
rv_result.sv
rv_core.sv
tb_wb_mem.sv
tb_rv_core.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary -f list.f --top-module tb_rv_core -o sim_tb_rv_core
out=$(./obj_dir/sim_tb_rv_core)
echo "$out"
if echo "$out" | grep -q "Test completed successfully"; then
  exit 0
else
  exit 1
fi
